// ==== design/alu_settings.svh ====
// Build settings for the integer ALU lane datapath and shifter
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width
`define DATA_WIDTH 32

// ROB tag width, enough for a 16-entry reorder buffer
`define TAG_WIDTH 4

// Sign fill for the arithmetic right shift opcode
// Set to 1'b0 and ASR shifts in zeros just like LSR
`define ENABLE_ASR 1'b1

`endif

// ==== design/alu_opcode_pkg.sv ====
// Opcode bus encoding for the integer ALU lane
`default_nettype none

`include "alu_settings.svh"

package alu_opcode_pkg;

   // One bit per operation on the one-hot opcode bus
   typedef enum logic [4:0] {
      ADD    = 5'd0,
      SUB    = 5'd1,
      AND    = 5'd2,
      OR     = 5'd3,
      XOR    = 5'd4,
      LSL    = 5'd5,
      LSR    = 5'd6,
      ASR    = 5'd7,
      MHI    = 5'd8,
      BEQ    = 5'd9,
      BNE    = 5'd10,
      BLTU   = 5'd11,
      BLT    = 5'd12,
      BGEU   = 5'd13,
      BGE    = 5'd14,
      JMPREG = 5'd15,
      JMPREL = 5'd16
   } alu_op_e;

   parameter int OPC_WIDTH = 17;

   // Shift amount field taken from the low bits of operand two
   parameter int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

endpackage

`default_nettype wire

// ==== design/alu_bundle_pkg.sv ====
// Payload structs carried by the ALU lane pipeline stages
`default_nettype none

`include "alu_settings.svh"

package alu_bundle_pkg;

   import alu_opcode_pkg::*;

   // Operand stage payload as accepted from issue
   typedef struct packed {
      logic [OPC_WIDTH-1:0]   opcode;
      logic [`DATA_WIDTH-1:0] operand_a;
      logic [`DATA_WIDTH-1:0] operand_b;
      logic [14:0]            rel15;
      logic [`TAG_WIDTH-1:0]  tag;
   } alu_issue_t;

   // Result stage payload handed to the ROB
   typedef struct packed {
      logic [`DATA_WIDTH-1:0] data;
      logic [`TAG_WIDTH-1:0]  tag;
      logic                   branch_reg_taken;
      logic                   branch_rel_taken;
      logic                   branch_op;
   } alu_result_t;

endpackage

`default_nettype wire

// ==== design/pipe_buffer.sv ====
// Single-entry flushable valid/ready pipeline register for any payload type
`timescale 1ns/100ps
`default_nettype none

module pipe_buffer
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     reset,
   input  logic     flush,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     valid_q;
   payload_t data_q;

   // Room when empty or when the held entry leaves this cycle
   // Nothing is taken while flushing
   assign in_ready = ~flush & (~valid_q | out_ready);

   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         valid_q <= 1'b0;
      end
      else if (in_ready)
      begin
         valid_q <= in_valid;
      end
   end

   // Payload loads only on an input transfer
   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
      begin
         data_q <= in_data;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== design/alu_adder_compare.sv ====
// Shared adder and subtractor with compare flags and conditional branch decision
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_adder_compare
(
   input  logic [alu_opcode_pkg::OPC_WIDTH-1:0] opcode,
   input  logic [`DATA_WIDTH-1:0]              operand_a,
   input  logic [`DATA_WIDTH-1:0]              operand_b,
   output logic [`DATA_WIDTH-1:0]              sum,
   output logic                                cond_taken,
   output logic                                cond_op
);

   import alu_opcode_pkg::*;

   localparam int MSB = `DATA_WIDTH - 1;

   logic                   sub_mode;
   logic [`DATA_WIDTH-1:0] addend;
   logic                   carry_out;
   logic                   overflow;
   logic                   cmp_eq;
   logic                   cmp_lt_s;
   logic                   cmp_lt_u;

   // Any conditional branch
   assign cond_op = opcode[BEQ] | opcode[BNE] | opcode[BLTU] |
                    opcode[BLT] | opcode[BGEU] | opcode[BGE];

   // Branches compare by subtracting, a - b = a + ~b + 1
   assign sub_mode = opcode[SUB] | cond_op;
   assign addend   = sub_mode ? ~operand_b : operand_b;

   assign {carry_out, sum} = {1'b0, operand_a} + {1'b0, addend} +
                             {{`DATA_WIDTH{1'b0}}, sub_mode};

   // Same-sign inputs giving an opposite-sign result
   assign overflow = (operand_a[MSB] == addend[MSB]) &
                     (operand_a[MSB] ^ sum[MSB]);

   assign cmp_eq   = (operand_a == operand_b);
   assign cmp_lt_s = sum[MSB] ^ overflow;
   // A borrow shows up as a missing carry
   assign cmp_lt_u = ~carry_out;

   assign cond_taken = (opcode[BEQ]  &  cmp_eq)   |
                       (opcode[BNE]  & ~cmp_eq)   |
                       (opcode[BLTU] &  cmp_lt_u) |
                       (opcode[BLT]  &  cmp_lt_s) |
                       (opcode[BGEU] & ~cmp_lt_u) |
                       (opcode[BGE]  & ~cmp_lt_s);

endmodule

`default_nettype wire

// ==== design/alu_shifter.sv ====
// Barrel shifter for left, logical right and arithmetic right shifts
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_shifter
(
   input  logic [alu_opcode_pkg::OPC_WIDTH-1:0]   opcode,
   input  logic [`DATA_WIDTH-1:0]                operand_a,
   input  logic [alu_opcode_pkg::SHAMT_WIDTH-1:0] shamt,
   output logic [`DATA_WIDTH-1:0]                shifted
);

   import alu_opcode_pkg::*;

   logic                     shift_left;
   logic                     fill_bit;
   logic [`DATA_WIDTH-1:0]   shift_in;
   logic [2*`DATA_WIDTH-1:0] shift_wide;
   logic [`DATA_WIDTH-1:0]   shift_right;

   function automatic logic [`DATA_WIDTH-1:0] reverse_bits(input logic [`DATA_WIDTH-1:0] a);
      logic [`DATA_WIDTH-1:0] r;
      for (int i = 0; i < `DATA_WIDTH; i++)
      begin
         r[`DATA_WIDTH-1-i] = a[i];
      end
      return r;
   endfunction

   assign shift_left = opcode[LSL];
   assign fill_bit   = opcode[ASR] & `ENABLE_ASR & operand_a[`DATA_WIDTH-1];

   // Left shift is a right shift on the mirrored word
   assign shift_in    = shift_left ? reverse_bits(operand_a) : operand_a;
   assign shift_wide  = {{`DATA_WIDTH{fill_bit}}, shift_in} >> shamt;
   assign shift_right = shift_wide[`DATA_WIDTH-1:0];
   assign shifted     = shift_left ? reverse_bits(shift_right) : shift_right;

endmodule

`default_nettype wire

// ==== design/alu_execute.sv ====
// ALU execute logic, opcode decode and AND-OR merge of all results
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_execute
(
   input  logic [alu_opcode_pkg::OPC_WIDTH-1:0] opcode,
   input  logic [`DATA_WIDTH-1:0]              operand_a,
   input  logic [`DATA_WIDTH-1:0]              operand_b,
   input  logic [14:0]                         rel15,
   input  logic [`TAG_WIDTH-1:0]               tag,
   output alu_bundle_pkg::alu_result_t         result
);

   import alu_opcode_pkg::*;
   import alu_bundle_pkg::*;

   logic [`DATA_WIDTH-1:0] dat_adder;
   logic [`DATA_WIDTH-1:0] dat_shifter;
   logic [`DATA_WIDTH-1:0] dat_move;
   logic [`DATA_WIDTH-1:0] dat_branch;
   logic [`DATA_WIDTH-1:0] rel_offset;
   logic                   sel_adder;
   logic                   sel_shifter;
   logic                   sel_branch;
   logic                   cond_taken;
   logic                   cond_op;
   logic                   reg_taken;
   logic                   rel_taken;

   alu_adder_compare u_adder_compare
   (
      .opcode     (opcode),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .sum        (dat_adder),
      .cond_taken (cond_taken),
      .cond_op    (cond_op)
   );

   alu_shifter u_shifter
   (
      .opcode    (opcode),
      .operand_a (operand_a),
      .shamt     (operand_b[SHAMT_WIDTH-1:0]),
      .shifted   (dat_shifter)
   );

   assign sel_adder   = opcode[ADD] | opcode[SUB];
   assign sel_shifter = opcode[LSL] | opcode[LSR] | opcode[ASR];

   // Move high places the low bits of operand two above bit 15
   assign dat_move = {operand_b[`DATA_WIDTH-16:0], 15'b0};

   assign reg_taken = opcode[JMPREG];
   assign rel_taken = cond_taken | opcode[JMPREL];

   // Word offset, sign extended and scaled to bytes
   assign rel_offset = {{(`DATA_WIDTH-17){rel15[14]}}, rel15, 2'b00};

   // Register jump target is operand one, unchecked for alignment
   assign dat_branch = rel_taken ? rel_offset : operand_a;
   // Not-taken conditional branch selects nothing and reads as zero
   assign sel_branch = reg_taken | rel_taken;

   always_comb
   begin
      result.data =
         ({`DATA_WIDTH{sel_adder}}    & dat_adder)              |
         ({`DATA_WIDTH{opcode[AND]}}  & (operand_a & operand_b)) |
         ({`DATA_WIDTH{opcode[OR]}}   & (operand_a | operand_b)) |
         ({`DATA_WIDTH{opcode[XOR]}}  & (operand_a ^ operand_b)) |
         ({`DATA_WIDTH{sel_shifter}}  & dat_shifter)            |
         ({`DATA_WIDTH{opcode[MHI]}}  & dat_move)               |
         ({`DATA_WIDTH{sel_branch}}   & dat_branch);
      result.tag              = tag;
      result.branch_reg_taken = reg_taken;
      result.branch_rel_taken = rel_taken;
      result.branch_op        = cond_op | opcode[JMPREG] | opcode[JMPREL];
   end

endmodule

`default_nettype wire

// ==== design/alu_top.sv ====
// Integer ALU lane with operand stage, execute logic and result stage
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_top
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                flush,
   // Issue side
   input  logic                                in_valid,
   output logic                                in_ready,
   input  logic [alu_opcode_pkg::OPC_WIDTH-1:0] opcode,
   input  logic [`DATA_WIDTH-1:0]              operand_a,
   input  logic [`DATA_WIDTH-1:0]              operand_b,
   input  logic [14:0]                         rel15,
   input  logic [`TAG_WIDTH-1:0]               in_tag,
   // Result side toward the ROB
   output logic                                out_valid,
   input  logic                                out_ready,
   output logic [`DATA_WIDTH-1:0]              out_data,
   output logic [`TAG_WIDTH-1:0]               out_tag,
   output logic                                branch_reg_taken,
   output logic                                branch_rel_taken,
   output logic                                branch_op
);

   import alu_bundle_pkg::*;

   alu_issue_t  issue_in;
   alu_issue_t  issue_q;
   alu_result_t exec_result;
   alu_result_t result_q;
   logic        op_valid;
   logic        res_ready;

   assign issue_in = '{opcode: opcode, operand_a: operand_a, operand_b: operand_b,
                       rel15: rel15, tag: in_tag};

   pipe_buffer #(.payload_t(alu_issue_t)) u_operand_stage
   (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (issue_in),
      .out_valid (op_valid),
      .out_ready (res_ready),
      .out_data  (issue_q)
   );

   alu_execute u_execute
   (
      .opcode    (issue_q.opcode),
      .operand_a (issue_q.operand_a),
      .operand_b (issue_q.operand_b),
      .rel15     (issue_q.rel15),
      .tag       (issue_q.tag),
      .result    (exec_result)
   );

   pipe_buffer #(.payload_t(alu_result_t)) u_result_stage
   (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .in_valid  (op_valid),
      .in_ready  (res_ready),
      .in_data   (exec_result),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (result_q)
   );

   assign out_data         = result_q.data;
   assign out_tag          = result_q.tag;
   assign branch_reg_taken = result_q.branch_reg_taken;
   assign branch_rel_taken = result_q.branch_rel_taken;
   assign branch_op        = result_q.branch_op;

endmodule

`default_nettype wire

// ==== verification/alu_checker.sv ====
// Concurrent assertions on the ALU lane handshake and opcode bus
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_checker
(
   input logic                                 clk,
   input logic                                 reset,
   input logic                                 flush,
   input logic                                 in_valid,
   input logic [alu_opcode_pkg::OPC_WIDTH-1:0] opcode,
   input logic                                 out_valid,
   input logic                                 out_ready,
   input logic [`DATA_WIDTH-1:0]               out_data,
   input logic [`TAG_WIDTH-1:0]                out_tag
);

   // At most one operation on the opcode bus
   a_opcode_onehot: assert property (
      @(posedge clk) disable iff (reset)
      in_valid |-> $onehot0(opcode))
      else $error("opcode bus has more than one bit set while in_valid is high");

   // A stalled result keeps its payload
   a_result_hold: assert property (
      @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_tag)))
      else $error("result payload changed while out_ready was low");

   a_clear_after_flush: assert property (
      @(posedge clk)
      (reset || flush) |=> !out_valid)
      else $error("out_valid high in the cycle after reset or flush");

endmodule

bind alu_top alu_checker u_checker (.*);

`default_nettype wire

// ==== verification/alu_tb.sv ====
// Testbench for the integer ALU lane with table stimulus, random back-pressure and flush
`timescale 1ns/100ps
`default_nettype none

`include "alu_settings.svh"

module alu_tb;

   import alu_opcode_pkg::*;

   localparam int DW      = `DATA_WIDTH;
   localparam int TIMEOUT = 40;

   typedef struct packed {
      logic [DW-1:0]         data;
      logic [`TAG_WIDTH-1:0] tag;
      logic [2:0]            flags;
      logic [31:0]           cycle;
   } expect_t;

   logic                  clk;
   logic                  reset;
   logic                  flush;
   logic                  in_valid;
   logic                  in_ready;
   logic [OPC_WIDTH-1:0]  opcode;
   logic [DW-1:0]         operand_a;
   logic [DW-1:0]         operand_b;
   logic [14:0]           rel15;
   logic [`TAG_WIDTH-1:0] in_tag;
   logic                  out_valid;
   logic                  out_ready;
   logic [DW-1:0]         out_data;
   logic [`TAG_WIDTH-1:0] out_tag;
   logic                  branch_reg_taken;
   logic                  branch_rel_taken;
   logic                  branch_op;

   // Stimulus table with expected {data, reg taken, rel taken, branch op}
   alu_op_e               tab_op[$];
   logic [DW-1:0]         tab_a[$];
   logic [DW-1:0]         tab_b[$];
   logic [14:0]           tab_rel[$];
   logic [DW+2:0]         tab_exp[$];
   expect_t               pending[$];
   expect_t               cur_exp;
   logic [15:0]           lfsr;
   logic [31:0]           cyc;
   logic [`TAG_WIDTH-1:0] next_tag;
   logic                  ready_seen;
   int                    ready_mode;

   alu_top dut0 (.*);

   always #20 clk = ~clk;

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [DW-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[DW-2:0], lfsr[0]};
      end
   endtask

   // Expected lane response for one operation
   function automatic logic [DW+2:0] model_op(input alu_op_e op, input logic [DW-1:0] a,
                                              input logic [DW-1:0] b, input logic [14:0] rel);
      int            rel_words;
      logic [DW-1:0] off;
      logic          taken;
      // Offset in words turned into bytes
      rel_words = $signed(rel);
      off       = rel_words * 4;
      taken = (op == BEQ && a == b) || (op == BNE && a != b) ||
              (op == BLTU && a < b) || (op == BLT && $signed(a) < $signed(b)) ||
              (op == BGEU && a >= b) || (op == BGE && $signed(a) >= $signed(b));
      case (op)
         ADD:    return {a + b, 3'b000};
         SUB:    return {a - b, 3'b000};
         AND:    return {a & b, 3'b000};
         OR:     return {a | b, 3'b000};
         XOR:    return {a ^ b, 3'b000};
         LSL:    return {a << b[4:0], 3'b000};
         LSR:    return {a >> b[4:0], 3'b000};
         ASR:    return {(`ENABLE_ASR) ? DW'($signed(a) >>> b[4:0]) : (a >> b[4:0]), 3'b000};
         MHI:    return {b << 15, 3'b000};
         JMPREG: return {a, 3'b101};
         JMPREL: return {off, 3'b011};
         default: return {taken ? off : {DW{1'b0}}, 1'b0, taken, 1'b1};
      endcase
   endfunction

   task automatic add_entry(input alu_op_e op, input logic [DW-1:0] a, input logic [DW-1:0] b,
                            input logic [14:0] rel);
      tab_op.push_back(op);
      tab_a.push_back(a);
      tab_b.push_back(b);
      tab_rel.push_back(rel);
      tab_exp.push_back(model_op(op, a, b, rel));
   endtask

   task automatic compare_value(input string name, input logic [DW-1:0] got,
                                input logic [DW-1:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic stall_fail(input string what);
      $display("The lane stalled, no %s within %0d cycles at %0t", what, TIMEOUT, $time);
      $display("Test FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic set_ready;
      if (ready_mode == 2)
      begin
         lfsr      = lfsr_next(lfsr);
         out_ready = lfsr[0];
      end
      else
         out_ready = (ready_mode == 1);
   endtask

   // Sample both handshakes mid-cycle, then move on to the next falling edge
   task automatic sample_cycle(output logic accepted);
      expect_t e;
      #10;
      accepted   = in_valid & in_ready;
      ready_seen = in_ready;
      if (out_valid && out_ready)
      begin
         if (pending.size() == 0)
         begin
            $display("Unexpected result with tag %h at %0t while nothing was outstanding",
                     out_tag, $time);
            $display("Test FAILED");
            $fatal(1, "unexpected result");
         end
         else
         begin
            e = pending.pop_front();
            compare_value("out_tag", out_tag, e.tag);
            compare_value("out_data", out_data, e.data);
            compare_value("branch_reg_taken", branch_reg_taken, e.flags[2]);
            compare_value("branch_rel_taken", branch_rel_taken, e.flags[1]);
            compare_value("branch_op", branch_op, e.flags[0]);
            if (ready_mode == 1)
               compare_value("latency", cyc - e.cycle, 2);
         end
      end
      if (accepted)
      begin
         cur_exp.cycle = cyc;
         pending.push_back(cur_exp);
      end
      @(negedge clk);
      cyc = cyc + 1;
      set_ready();
   endtask

   task automatic issue_op(input int i);
      logic accepted;
      int   waited;
      opcode            = '0;
      opcode[tab_op[i]] = 1'b1;
      operand_a         = tab_a[i];
      operand_b         = tab_b[i];
      rel15             = tab_rel[i];
      in_tag            = next_tag;
      in_valid          = 1'b1;
      cur_exp.data      = tab_exp[i][DW+2:3];
      cur_exp.flags     = tab_exp[i][2:0];
      cur_exp.tag       = next_tag;
      waited            = 0;
      accepted          = 1'b0;
      while (!accepted)
      begin
         if (waited == TIMEOUT)
            stall_fail("in_ready");
         sample_cycle(accepted);
         waited++;
      end
      in_valid = 1'b0;
      next_tag = next_tag + 1'b1;
   endtask

   task automatic drain;
      logic accepted;
      int   waited;
      waited = 0;
      while (pending.size() != 0)
      begin
         if (waited == TIMEOUT)
            stall_fail("out_valid transfer");
         sample_cycle(accepted);
         waited++;
      end
   endtask

   task automatic run_table(input int mode);
      ready_mode = mode;
      set_ready();
      for (int i = 0; i < tab_op.size(); i++)
      begin
         issue_op(i);
      end
      drain();
   endtask

   task automatic build_table;
      logic [DW-1:0] rnd;
      logic [DW-1:0] amt[4];
      logic [DW-1:0] pair_a[3];
      logic [DW-1:0] pair_b[3];
      // Wraparound and signed overflow on both add and subtract
      add_entry(ADD, 32'd5, 32'd7, 15'd0);
      add_entry(ADD, 32'hffff_ffff, 32'd1, 15'd0);
      add_entry(ADD, 32'h7fff_ffff, 32'd1, 15'd0);
      add_entry(SUB, 32'd0, 32'd1, 15'd0);
      add_entry(SUB, 32'h8000_0000, 32'd1, 15'd0);
      add_entry(AND, 32'hf0f0_1234, 32'h0ff0_ffff, 15'd0);
      add_entry(OR, 32'hf0f0_1234, 32'h0ff0_0001, 15'd0);
      add_entry(XOR, 32'hf0f0_1234, 32'h0ff0_ffff, 15'd0);
      add_entry(MHI, 32'd0, 32'hfffd_abcd, 15'h7fff);
      draw_bits(5, rnd);
      amt = '{32'd0, 32'd1, 32'd31, rnd};
      for (int s = 0; s < 3; s++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            add_entry(alu_op_e'(LSL + s), 32'h8765_4321, amt[k], 15'd0);
            add_entry(alu_op_e'(LSL + s), 32'h1234_5678, amt[k], 15'd0);
         end
      end
      // Equal, signed less but unsigned greater, greater
      pair_a = '{32'd5, 32'hffff_fff0, 32'd100};
      pair_b = '{32'd5, 32'd5, 32'd7};
      for (int c = 0; c < 6; c++)
      begin
         for (int p = 0; p < 3; p++)
         begin
            add_entry(alu_op_e'(BEQ + c), pair_a[p], pair_b[p], (p == 1) ? 15'h7f00 : 15'h0123);
         end
      end
      add_entry(JMPREG, 32'h1234_5678, 32'd0, 15'h0155);
      add_entry(JMPREL, 32'd0, 32'd0, 15'h0040);
      add_entry(JMPREL, 32'd0, 32'd0, 15'h7ff0);
   endtask

   initial
   begin
      logic accepted;
      clk        = 1'b0;
      reset      = 1'b1;
      flush      = 1'b0;
      in_valid   = 1'b0;
      opcode     = '0;
      operand_a  = '0;
      operand_b  = '0;
      rel15      = '0;
      in_tag     = '0;
      out_ready  = 1'b0;
      lfsr       = 16'd3175;
      cyc        = 0;
      next_tag   = '0;
      ready_mode = 0;
      build_table();
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      run_table(1);
      run_table(2);
      // Two operations held in the lane, then dropped by flush
      ready_mode = 0;
      set_ready();
      issue_op(0);
      issue_op(1);
      compare_value("out_valid", out_valid, 1'b1);
      compare_value("in_ready", in_ready, 1'b0);
      flush = 1'b1;
      sample_cycle(accepted);
      flush = 1'b0;
      compare_value("out_valid", out_valid, 1'b0);
      // Idle cycle where a surviving operand would move on to the result stage
      sample_cycle(accepted);
      compare_value("in_ready", ready_seen, 1'b1);
      compare_value("out_valid", out_valid, 1'b0);
      pending.delete();
      ready_mode = 1;
      set_ready();
      issue_op(2);
      drain();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/alu_opcode_pkg.sv
design/alu_bundle_pkg.sv
design/pipe_buffer.sv
design/alu_adder_compare.sv
design/alu_shifter.sv
design/alu_execute.sv
design/alu_top.sv
verification/alu_checker.sv
verification/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu_lane

export_include_dirs:
  - design

sources:
  # Design
  - include_dirs:
      - design
    files:
      - design/alu_opcode_pkg.sv
      - design/alu_bundle_pkg.sv
      - design/pipe_buffer.sv
      - design/alu_adder_compare.sv
      - design/alu_shifter.sv
      - design/alu_execute.sv
      - design/alu_top.sv
  # Verification
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/alu_checker.sv
      - verification/alu_tb.sv
